// File: Makefile
# Verilator build and run of the control plane testbench

VERILATOR ?= verilator
TOP       ?= tb_u2_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.DEFAULT_GOAL := help
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim.f
source/u2_ctrl_pkg.sv
source/host_bus_decode.sv
source/settings_bridge.sv
source/control_regs.sv
source/simple_pic.sv
source/status_readback.sv
source/u2_ctrl_top.sv
tests/tb_u2_ctrl.sv

// File: source/control_regs.sv
/* Board control settings. Only the low bits of each word are kept,
   writes to unused addresses are dropped. PHY reset is active low. */
`timescale 1ns/1ps

module control_regs import u2_ctrl_pkg::*; (
   input  logic              dsp_clk,
   input  logic              reset_i,
   input  logic              set_stb_i,
   input  logic [SET_AW-1:0] set_addr_i,
   input  logic [DW-1:0]     set_data_i,
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   output logic              ser_enable_o,
   output logic              ser_prbsen_o,
   output logic              ser_loopen_o,
   output logic              ser_rx_en_o,
   output logic              adc_oe_a_o,
   output logic              adc_on_a_o,
   output logic              adc_oe_b_o,
   output logic              adc_on_b_o,
   output logic [7:0]        leds_o,
   output logic              phy_resetn_o,
   output logic              debug_sel_o
);

   logic [4:0] clock_r;
   logic [3:0] serdes_r;
   logic [3:0] adc_r;
   logic [7:0] leds_r;
   logic phy_reset_r;
   logic debug_r;

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         clock_r <= '0;
         serdes_r <= '0;
         adc_r <= '0;
         leds_r <= '0;
         phy_reset_r <= 1'b0;
         debug_r <= 1'b0;
      end else if (set_stb_i) begin
         case (set_addr_e'(set_addr_i))
            SET_CLOCK:  clock_r <= set_data_i[4:0];
            SET_SERDES: serdes_r <= set_data_i[3:0];
            SET_ADC:    adc_r <= set_data_i[3:0];
            SET_LEDS:   leds_r <= set_data_i[7:0];
            SET_PHY:    phy_reset_r <= set_data_i[0];
            SET_DEBUG:  debug_r <= set_data_i[0];
            default: ;
         endcase
      end
   end

   ////////////////////
   // Bit fields onto the board lines
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_r;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_r;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_r;
   assign leds_o = leds_r;
   assign phy_resetn_o = ~phy_reset_r;
   assign debug_sel_o = debug_r;

   // The bridge only ever strobes once per host access
   stb_single: assert property (@(posedge dsp_clk) disable iff (reset_i)
      set_stb_i |=> !set_stb_i);

endmodule

// File: source/host_bus_decode.sv
/* The host strobes for a single cycle and waits for ack or err,
   which always come exactly one cycle later. */
`timescale 1ns/1ps

module host_bus_decode import u2_ctrl_pkg::*; (
   input  logic          dsp_clk,
   input  logic          reset_i,
   input  logic          hb_stb_i,
   input  logic          hb_we_i,
   input  logic [AW-1:0] hb_adr_i,
   output logic [DW-1:0] hb_dat_o,
   output logic          hb_ack_o,
   output logic          hb_err_o,
   output logic          set_sel_o,
   output logic          pic_sel_o,
   output logic          stat_sel_o,
   input  logic [DW-1:0] pic_dat_i,
   input  logic [DW-1:0] stat_dat_i
);

   bus_region_e region;
   logic [DW-1:0] rd_mux;

   // Prefix decode
   always_comb begin
      case (hb_adr_i[AW-1 -: REGION_W])
         PFX_STATUS:   region = REGION_STATUS;
         PFX_SETTINGS: region = REGION_SETTINGS;
         PFX_PIC:      region = REGION_PIC;
         default:      region = REGION_NONE;
      endcase
   end

   assign set_sel_o = hb_stb_i && (region == REGION_SETTINGS);
   assign pic_sel_o = hb_stb_i && (region == REGION_PIC);
   assign stat_sel_o = hb_stb_i && (region == REGION_STATUS);

   // Settings region reads back as zero
   always_comb begin
      case (region)
         REGION_STATUS: rd_mux = stat_dat_i;
         REGION_PIC:    rd_mux = pic_dat_i;
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         hb_ack_o <= 1'b0;
         hb_err_o <= 1'b0;
         hb_dat_o <= '0;
      end else begin
         hb_ack_o <= hb_stb_i && (region != REGION_NONE);
         hb_err_o <= hb_stb_i && (region == REGION_NONE);
         if (hb_stb_i && !hb_we_i)
            hb_dat_o <= rd_mux;
      end
   end

   ////////////////////
   // Bus protocol checks
   ack_err_excl: assert property (@(posedge dsp_clk) disable iff (reset_i)
      !(hb_ack_o && hb_err_o));

endmodule

// File: source/settings_bridge.sv
/* Write-only bridge; set_stb_o lines up with the host ack.
   Reads of the settings region are answered by the decoder. */
`timescale 1ns/1ps

module settings_bridge import u2_ctrl_pkg::*; (
   input  logic              dsp_clk,
   input  logic              reset_i,
   input  logic              set_sel_i,
   input  logic              hb_we_i,
   input  logic [AW-1:0]     hb_adr_i,
   input  logic [DW-1:0]     hb_dat_i,
   output logic              set_stb_o,
   output logic [SET_AW-1:0] set_addr_o,
   output logic [DW-1:0]     set_data_o
);

   logic wr_en;

   assign wr_en = set_sel_i && hb_we_i;

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         set_stb_o <= 1'b0;
         set_addr_o <= '0;
         set_data_o <= '0;
      end else begin
         set_stb_o <= wr_en;
         // Word address of the setting
         if (wr_en) begin
            set_addr_o <= hb_adr_i[SET_AW+1:2];
            set_data_o <= hb_dat_i;
         end
      end
   end

endmodule

// File: source/simple_pic.sv
/* Lines pend when they equal their polarity bit, so an idle-low line with
   polarity 0 in level mode pends right after reset. NUM_IRQ < DW. */
`timescale 1ns/1ps

module simple_pic import u2_ctrl_pkg::*; #(
   parameter int NUM_IRQ = NUM_IRQ_DEF
) (
   input  logic               dsp_clk,
   input  logic               reset_i,
   input  logic               pic_sel_i,
   input  logic               hb_we_i,
   input  logic [AW-1:0]      hb_adr_i,
   input  logic [DW-1:0]      hb_dat_i,
   output logic [DW-1:0]      pic_dat_o,
   input  logic [NUM_IRQ-1:0] irq_i,
   output logic               int_o
);

   logic [NUM_IRQ-1:0] edge_r;
   logic [NUM_IRQ-1:0] pol_r;
   logic [NUM_IRQ-1:0] mask_r;
   logic [NUM_IRQ-1:0] pend_r;
   logic [NUM_IRQ-1:0] irq_q;
   logic [NUM_IRQ-1:0] hit_now;
   logic [NUM_IRQ-1:0] hit_prev;
   logic [NUM_IRQ-1:0] set_v;
   logic [NUM_IRQ-1:0] clr_v;
   logic [NUM_IRQ-1:0] rd_word;
   logic wr_en;
   pic_reg_e offset;

   assign offset = pic_reg_e'(hb_adr_i[3:2]);
   assign wr_en = pic_sel_i && hb_we_i;

   // Active now, and active at the previous sample
   assign hit_now = ~(irq_i ^ pol_r);
   assign hit_prev = ~(irq_q ^ pol_r);

   // Edge lines pend only on entering the active level
   assign set_v = hit_now & (~edge_r | ~hit_prev);
   assign clr_v = (wr_en && offset == PIC_PENDING) ? hb_dat_i[NUM_IRQ-1:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         edge_r <= '0;
         pol_r <= '0;
         mask_r <= '0;
         pend_r <= '0;
         irq_q <= '0;
      end else begin
         irq_q <= irq_i;
         // A new event in the clearing cycle keeps its bit
         pend_r <= (pend_r & ~clr_v) | set_v;
         if (wr_en) begin
            case (offset)
               PIC_EDGE:     edge_r <= hb_dat_i[NUM_IRQ-1:0];
               PIC_POLARITY: pol_r <= hb_dat_i[NUM_IRQ-1:0];
               PIC_MASK:     mask_r <= hb_dat_i[NUM_IRQ-1:0];
               default: ;
            endcase
         end
      end
   end

   ////////////////////
   // Readback and interrupt out
   always_comb begin
      case (offset)
         PIC_EDGE:     rd_word = edge_r;
         PIC_POLARITY: rd_word = pol_r;
         PIC_MASK:     rd_word = mask_r;
         default:      rd_word = pend_r;
      endcase
   end

   assign pic_dat_o = {{(DW-NUM_IRQ){1'b0}}, rd_word};
   assign int_o = |(pend_r & ~mask_r);

endmodule

// File: source/status_readback.sv
/* Status words lag their inputs by one cycle. Words 4 to 15 read zero.
   debug_o switches as soon as the debug select register does. */
`timescale 1ns/1ps

module status_readback import u2_ctrl_pkg::*; (
   input  logic          dsp_clk,
   input  logic          reset_i,
   input  logic [AW-1:0] hb_adr_i,
   output logic [DW-1:0] stat_dat_o,
   input  logic [31:0]   host_to_dsp_level_i,
   input  logic [31:0]   dsp_to_host_level_i,
   input  logic          sim_mode_i,
   input  logic [3:0]    clock_divider_i,
   input  logic          clk_func_i,
   input  logic          clk_status_i,
   input  logic          debug_sel_i,
   output logic [31:0]   debug_o
);

   logic [31:0] h2d_q;
   logic [31:0] d2h_q;
   logic [DW-1:0] misc_q;
   logic [DW-1:0] clk_q;

   // Words packed as they are served
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         h2d_q <= '0;
         d2h_q <= '0;
         misc_q <= '0;
         clk_q <= '0;
      end else begin
         h2d_q <= host_to_dsp_level_i;
         d2h_q <= dsp_to_host_level_i;
         misc_q <= {sim_mode_i, 27'd0, clock_divider_i};
         clk_q <= {30'd0, clk_func_i, clk_status_i};
      end
   end

   always_comb begin
      case (hb_adr_i[5:2])
         4'd0:    stat_dat_o = h2d_q;
         4'd1:    stat_dat_o = d2h_q;
         4'd2:    stat_dat_o = misc_q;
         4'd3:    stat_dat_o = clk_q;
         default: stat_dat_o = '0;
      endcase
   end

   assign debug_o = debug_sel_i ? h2d_q : d2h_q;

endmodule

// File: source/u2_ctrl_pkg.sv
/* Widths, region prefixes and register maps of the host control plane.
   Region prefixes sit in host address bits 15 to 10. */
package u2_ctrl_pkg;

   // Host bus and settings bus widths
   localparam int DW = 32;
   localparam int AW = 16;
   localparam int SET_AW = 8;
   localparam int NUM_IRQ_DEF = 9;

   ////////////////////
   // Address map
   localparam int REGION_W = 6;
   localparam logic [REGION_W-1:0] PFX_STATUS = 6'b110011;
   localparam logic [REGION_W-1:0] PFX_SETTINGS = 6'b110101;
   localparam logic [REGION_W-1:0] PFX_PIC = 6'b110110;

   typedef enum logic [1:0] {
      REGION_STATUS,
      REGION_SETTINGS,
      REGION_PIC,
      REGION_NONE
   } bus_region_e;

   // Setting addresses, host address bits 9 to 2
   typedef enum logic [SET_AW-1:0] {
      SET_CLOCK = 8'd0,
      SET_SERDES = 8'd1,
      SET_ADC = 8'd2,
      SET_LEDS = 8'd3,
      SET_PHY = 8'd4,
      SET_DEBUG = 8'd5
   } set_addr_e;

   // Interrupt controller word offsets
   typedef enum logic [1:0] {
      PIC_EDGE = 2'd0,
      PIC_POLARITY = 2'd1,
      PIC_MASK = 2'd2,
      PIC_PENDING = 2'd3
   } pic_reg_e;

endpackage

// File: source/u2_ctrl_top.sv
/* Host control plane on dsp_clk: decoder, settings bus, board control
   registers, interrupt controller and status readback. */
`timescale 1ns/1ps

module u2_ctrl_top import u2_ctrl_pkg::*; #(
   parameter int NUM_IRQ = NUM_IRQ_DEF
) (
   input  logic               dsp_clk,
   input  logic               reset_i,
   // Host bus
   input  logic               hb_stb_i,
   input  logic               hb_we_i,
   input  logic [AW-1:0]      hb_adr_i,
   input  logic [DW-1:0]      hb_dat_i,
   output logic [DW-1:0]      hb_dat_o,
   output logic               hb_ack_o,
   output logic               hb_err_o,
   // Interrupts
   input  logic [NUM_IRQ-1:0] irq_i,
   output logic               int_o,
   // Board control lines
   output logic               clock_ready_o,
   output logic [1:0]         clk_en_o,
   output logic [1:0]         clk_sel_o,
   output logic               ser_enable_o,
   output logic               ser_prbsen_o,
   output logic               ser_loopen_o,
   output logic               ser_rx_en_o,
   output logic               adc_oe_a_o,
   output logic               adc_on_a_o,
   output logic               adc_oe_b_o,
   output logic               adc_on_b_o,
   output logic [7:0]         leds_o,
   output logic               phy_resetn_o,
   // Status and debug
   input  logic [31:0]        host_to_dsp_level_i,
   input  logic [31:0]        dsp_to_host_level_i,
   input  logic               sim_mode_i,
   input  logic [3:0]         clock_divider_i,
   input  logic               clk_func_i,
   input  logic               clk_status_i,
   output logic [31:0]        debug_o
);

   logic set_sel;
   logic pic_sel;
   logic [DW-1:0] pic_dat;
   logic [DW-1:0] stat_dat;
   logic set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [DW-1:0] set_data;
   logic debug_sel;

   ////////////////////
   // Host side
   // Status reads are combinational and its writes are ignored, so no select
   host_bus_decode u_decode (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .hb_stb_i(hb_stb_i), .hb_we_i(hb_we_i), .hb_adr_i(hb_adr_i),
      .hb_dat_o(hb_dat_o), .hb_ack_o(hb_ack_o), .hb_err_o(hb_err_o),
      .set_sel_o(set_sel), .pic_sel_o(pic_sel), .stat_sel_o(),
      .pic_dat_i(pic_dat), .stat_dat_i(stat_dat));

   settings_bridge u_bridge (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .set_sel_i(set_sel), .hb_we_i(hb_we_i), .hb_adr_i(hb_adr_i), .hb_dat_i(hb_dat_i),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ////////////////////
   // Slaves
   control_regs u_regs (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .leds_o(leds_o), .phy_resetn_o(phy_resetn_o), .debug_sel_o(debug_sel));

   simple_pic #(.NUM_IRQ(NUM_IRQ)) u_pic (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .pic_sel_i(pic_sel), .hb_we_i(hb_we_i), .hb_adr_i(hb_adr_i), .hb_dat_i(hb_dat_i),
      .pic_dat_o(pic_dat), .irq_i(irq_i), .int_o(int_o));

   status_readback u_status (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .hb_adr_i(hb_adr_i), .stat_dat_o(stat_dat),
      .host_to_dsp_level_i(host_to_dsp_level_i),
      .dsp_to_host_level_i(dsp_to_host_level_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .clk_func_i(clk_func_i), .clk_status_i(clk_status_i),
      .debug_sel_i(debug_sel), .debug_o(debug_o));

endmodule

// File: tests/tb_u2_ctrl.sv
/* Host accesses are serialized and each strobe waits for its ack or err.
   The irq lines idle high with polarity 0, so no line pends after reset. */
`timescale 1ns/1ps

module tb_u2_ctrl import u2_ctrl_pkg::*; ();

   localparam int NUM_IRQ = NUM_IRQ_DEF;
   localparam int ACK_TIMEOUT = 16;
   localparam logic [31:0] LFSR_SEED = 32'h63c8_8e8e;

   logic dsp_clk = 1'b0;
   logic reset_i = 1'b1;
   logic hb_stb_i = 1'b0;
   logic hb_we_i = 1'b0;
   logic [AW-1:0] hb_adr_i = '0;
   logic [DW-1:0] hb_dat_i = '0;
   logic [DW-1:0] hb_dat_o;
   logic hb_ack_o;
   logic hb_err_o;
   logic [NUM_IRQ-1:0] irq_i = '1;
   logic int_o;
   logic clock_ready_o, ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o;
   logic adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o, phy_resetn_o;
   logic [1:0] clk_en_o;
   logic [1:0] clk_sel_o;
   logic [7:0] leds_o;
   logic [31:0] host_to_dsp_level_i = 32'h0123_4567;
   logic [31:0] dsp_to_host_level_i = 32'h89ab_cdef;
   logic sim_mode_i = 1'b0;
   logic [3:0] clock_divider_i = 4'd0;
   logic clk_func_i = 1'b0;
   logic clk_status_i = 1'b0;
   logic [31:0] debug_o;

   // Control lines in the order of the setting bit fields
   logic [21:0] ctrl_obs;
   assign ctrl_obs = {phy_resetn_o, leds_o, adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o,
                      ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o,
                      clock_ready_o, clk_en_o, clk_sel_o};

   // Model state
   logic [31:0] lfsr_state = LFSR_SEED;
   logic [21:0] m_ctrl = 22'h20_0000;
   logic m_dbg = 1'b0;
   logic [NUM_IRQ-1:0] m_edge, m_pol, m_mask, m_pend, m_irq_prev;

   u2_ctrl_top #(.NUM_IRQ(NUM_IRQ)) UUT (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .hb_stb_i(hb_stb_i), .hb_we_i(hb_we_i), .hb_adr_i(hb_adr_i), .hb_dat_i(hb_dat_i),
      .hb_dat_o(hb_dat_o), .hb_ack_o(hb_ack_o), .hb_err_o(hb_err_o),
      .irq_i(irq_i), .int_o(int_o),
      .clock_ready_o(clock_ready_o), .clk_en_o(clk_en_o), .clk_sel_o(clk_sel_o),
      .ser_enable_o(ser_enable_o), .ser_prbsen_o(ser_prbsen_o),
      .ser_loopen_o(ser_loopen_o), .ser_rx_en_o(ser_rx_en_o),
      .adc_oe_a_o(adc_oe_a_o), .adc_on_a_o(adc_on_a_o),
      .adc_oe_b_o(adc_oe_b_o), .adc_on_b_o(adc_on_b_o),
      .leds_o(leds_o), .phy_resetn_o(phy_resetn_o),
      .host_to_dsp_level_i(host_to_dsp_level_i), .dsp_to_host_level_i(dsp_to_host_level_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .clk_func_i(clk_func_i), .clk_status_i(clk_status_i), .debug_o(debug_o));

   always #4 dsp_clk = ~dsp_clk;

   ////////////////////
   // Reference functions
   function automatic logic [21:0] ctrl_next(logic [21:0] cur, logic [7:0] sa, logic [31:0] d);
      logic [21:0] n;
      n = cur;
      case (sa)
         SET_CLOCK:  n[4:0] = d[4:0];
         SET_SERDES: n[8:5] = d[3:0];
         SET_ADC:    n[12:9] = d[3:0];
         SET_LEDS:   n[20:13] = d[7:0];
         SET_PHY:    n[21] = ~d[0];
         default: ;
      endcase
      return n;
   endfunction

   function automatic logic [31:0] status_word(int w);
      logic [31:0] v;
      v = '0;
      case (w)
         0: v = host_to_dsp_level_i;
         1: v = dsp_to_host_level_i;
         2: begin
            v[31] = sim_mode_i;
            v[3:0] = clock_divider_i;
         end
         3: v[1:0] = {clk_func_i, clk_status_i};
         default: ;
      endcase
      return v;
   endfunction

   // Next pending bits from one irq sample
   function automatic logic [NUM_IRQ-1:0] pending_next(
         logic [NUM_IRQ-1:0] pend, logic [NUM_IRQ-1:0] edg, logic [NUM_IRQ-1:0] pol,
         logic [NUM_IRQ-1:0] now, logic [NUM_IRQ-1:0] prev, logic [NUM_IRQ-1:0] clr);
      logic [NUM_IRQ-1:0] n;
      logic active;
      logic was;
      for (int i = 0; i < NUM_IRQ; i++) begin
         active = (now[i] == pol[i]);
         was = (prev[i] == pol[i]);
         n[i] = (pend[i] && !clr[i]) || (edg[i] ? (active && !was) : active);
      end
      return n;
   endfunction

   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   ////////////////////
   // Interrupt controller model and int_o compare
   always @(posedge dsp_clk) begin : pic_model
      logic pic_wr;
      logic [NUM_IRQ-1:0] clr;
      pic_wr = hb_stb_i && hb_we_i && (hb_adr_i[15:10] == PFX_PIC);
      clr = (pic_wr && hb_adr_i[3:2] == 2'd3) ? hb_dat_i[NUM_IRQ-1:0] : '0;
      if (reset_i) begin
         m_edge <= '0;
         m_pol <= '0;
         m_mask <= '0;
         m_pend <= '0;
         m_irq_prev <= '0;
      end else begin
         m_pend <= pending_next(m_pend, m_edge, m_pol, irq_i, m_irq_prev, clr);
         m_irq_prev <= irq_i;
         if (pic_wr && hb_adr_i[3:2] == 2'd0) m_edge <= hb_dat_i[NUM_IRQ-1:0];
         if (pic_wr && hb_adr_i[3:2] == 2'd1) m_pol <= hb_dat_i[NUM_IRQ-1:0];
         if (pic_wr && hb_adr_i[3:2] == 2'd2) m_mask <= hb_dat_i[NUM_IRQ-1:0];
      end
   end

   always @(negedge dsp_clk) begin
      if (!reset_i)
         check_value("int_o", 32'(int_o), 32'(|(m_pend & ~m_mask)));
   end

   ////////////////////
   // Helpers
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("** Error at %0t ns: %s got %h expected %h",
                             $time, name, got, exp));
   endtask

   task automatic step_cycle();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic random_bits(input int nbits, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = {val[30:0], lfsr_state[0]};
      end
   endtask

   // One strobe, then wait for the answer
   task automatic bus_access(input logic we, input logic [AW-1:0] adr,
                             input logic [DW-1:0] dat, output logic [DW-1:0] rdat,
                             output logic got_err);
      int cycles;
      hb_stb_i = 1'b1;
      hb_we_i = we;
      hb_adr_i = adr;
      hb_dat_i = dat;
      step_cycle();
      hb_stb_i = 1'b0;
      hb_we_i = 1'b0;
      cycles = 1;
      while (!hb_ack_o && !hb_err_o) begin
         if (cycles >= ACK_TIMEOUT)
            abort_run("Timeout while waiting for ack or err on the host bus");
         step_cycle();
         cycles++;
      end
      check_value("answer latency", 32'(cycles), 32'd1);
      check_value("ack with err", 32'(hb_ack_o & hb_err_o), 32'd0);
      rdat = hb_dat_o;
      got_err = hb_err_o;
   endtask

   task automatic host_write(input logic [AW-1:0] adr, input logic [DW-1:0] dat);
      logic [DW-1:0] rdat;
      logic got_err;
      bus_access(1'b1, adr, dat, rdat, got_err);
      check_value("hb_err_o", 32'(got_err), 32'd0);
   endtask

   task automatic host_read(input logic [AW-1:0] adr, output logic [DW-1:0] rdat);
      logic got_err;
      bus_access(1'b0, adr, '0, rdat, got_err);
      check_value("hb_err_o", 32'(got_err), 32'd0);
   endtask

   // Outputs hold through the ack cycle and change one cycle later
   task automatic settings_write(input logic [7:0] sa, input logic [31:0] d);
      logic [21:0] exp;
      exp = ctrl_next(m_ctrl, sa, d);
      host_write({PFX_SETTINGS, sa, 2'b00}, d);
      check_value("control lines at ack", 32'(ctrl_obs), 32'(m_ctrl));
      step_cycle();
      check_value("control lines", 32'(ctrl_obs), 32'(exp));
      m_ctrl = exp;
      if (sa == SET_DEBUG)
         m_dbg = d[0];
      check_value("debug_o", debug_o, m_dbg ? host_to_dsp_level_i : dsp_to_host_level_i);
   endtask

   task automatic pic_read_check(input logic [1:0] off, input logic [NUM_IRQ-1:0] exp);
      logic [DW-1:0] rdat;
      host_read({PFX_PIC, 6'd0, off, 2'b00}, rdat);
      check_value("pic readback", rdat, 32'(exp));
   endtask

   ////////////////////
   // Test sequence
   initial begin : test_sequence
      logic [31:0] r;
      logic [DW-1:0] rdat;
      logic got_err;
      repeat (8) @(posedge dsp_clk);
      #1;
      reset_i = 1'b0;
      step_cycle();
      check_value("control lines after reset", 32'(ctrl_obs), 32'h0020_0000);
      check_value("int_o after reset", 32'(int_o), 32'd0);
      check_value("debug_o after reset", debug_o, dsp_to_host_level_i);

      // Random settings including unused addresses
      for (int rnd = 0; rnd < 3; rnd++) begin
         for (int k = 0; k < 9; k++) begin
            random_bits(32, r);
            settings_write((k == 8) ? 8'ha5 : 8'(k), r);
         end
      end
      settings_write(SET_DEBUG, 32'd1);
      settings_write(SET_DEBUG, 32'd0);

      // Status words
      random_bits(32, r);
      host_to_dsp_level_i = r;
      random_bits(32, r);
      dsp_to_host_level_i = r;
      random_bits(7, r);
      {sim_mode_i, clock_divider_i, clk_func_i, clk_status_i} = r[6:0];
      step_cycle();
      host_write({PFX_STATUS, 10'h000}, 32'hffff_ffff);
      for (int w = 0; w < 16; w++) begin
         host_read({PFX_STATUS, 4'd0, 4'(w), 2'b00}, rdat);
         check_value("status word", rdat, status_word(w));
      end
      host_read({PFX_SETTINGS, 8'd3, 2'b00}, rdat);
      check_value("settings read", rdat, 32'd0);
      settings_write(SET_DEBUG, 32'd1);
      settings_write(SET_DEBUG, 32'd0);

      // Level mode on line 3 and then masked
      irq_i[3] = 1'b0;
      step_cycle();
      check_value("int_o level", 32'(int_o), 32'd1);
      host_write({PFX_PIC, 6'd0, 2'd2, 2'b00}, 32'h0000_0008);
      check_value("int_o masked", 32'(int_o), 32'd0);
      irq_i[3] = 1'b1;
      host_write({PFX_PIC, 6'd0, 2'd3, 2'b00}, 32'h0000_0008);
      host_write({PFX_PIC, 6'd0, 2'd2, 2'b00}, 32'h0000_0000);
      pic_read_check(2'd3, m_pend);

      // Edge mode on line 5 rising to polarity 1
      // Line 7 is edge mode too but stays away from its polarity
      host_write({PFX_PIC, 6'd0, 2'd0, 2'b00}, 32'h0000_00a0);
      host_write({PFX_PIC, 6'd0, 2'd1, 2'b00}, 32'h0000_0020);
      irq_i[5] = 1'b0;
      step_cycle();
      irq_i[5] = 1'b1;
      step_cycle();
      check_value("int_o edge", 32'(int_o), 32'd1);
      pic_read_check(2'd3, m_pend);
      host_write({PFX_PIC, 6'd0, 2'd3, 2'b00}, 32'h0000_0020);
      step_cycle();
      check_value("int_o after clear", 32'(int_o), 32'd0);
      host_write({PFX_PIC, 6'd0, 2'd2, 2'b00}, 32'h0000_0104);
      pic_read_check(2'd0, m_edge);
      pic_read_check(2'd1, m_pol);
      pic_read_check(2'd2, m_mask);
      pic_read_check(2'd3, m_pend);

      // Unmapped prefixes
      bus_access(1'b0, 16'h0000, '0, rdat, got_err);
      check_value("hb_err_o unmapped read", 32'(got_err), 32'd1);
      check_value("hb_ack_o unmapped read", 32'(hb_ack_o), 32'd0);
      bus_access(1'b1, 16'hfc00, 32'h5555_aaaa, rdat, got_err);
      check_value("hb_err_o unmapped write", 32'(got_err), 32'd1);
      check_value("hb_ack_o unmapped write", 32'(hb_ack_o), 32'd0);
      step_cycle();

      $display("STATUS: PASS");
      $finish;
   end

endmodule
